// File: rtl/tpu_pkg.sv
`default_nettype none

package tpu_pkg;

    localparam int ARRAY_N   = 4;
    localparam int DATA_W    = 8;
    localparam int ACC_W     = 32;
    localparam int MAX_ROWS  = 16;
    localparam int MAX_TILES = 4;
    localparam int UB_AW     = 8;
    localparam int ACC_AW    = 4;
    // buffer read + skew entry + array depth
    localparam int PIPE_LAT  = 6;

    typedef logic [ARRAY_N-1:0][DATA_W-1:0] act_row_t;
    typedef logic [ARRAY_N-1:0][ACC_W-1:0]  acc_row_t;
    typedef logic [ARRAY_N-1:0]             col_mask_t;

    typedef struct packed {
        logic [4:0]       rows;
        logic [2:0]       tiles;
        logic [UB_AW-1:0] ub_base;
    } tpu_cmd_t;

    typedef struct packed {
        logic              en;
        logic              add;
        logic [ACC_AW-1:0] row;
        col_mask_t         col_mask;
    } acc_wr_t;

    typedef enum logic [2:0] {
        IDLE,
        FILL_FIFO,
        LOAD_WEIGHTS,
        COMPUTE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        NO_OUTPUT,
        PARTIAL_OUTPUT,
        FULL_OUTPUT,
        REVERSE_PARTIAL
    } out_phase_e;

endpackage

`default_nettype wire

// File: rtl/weight_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module weight_fifo (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              wr_i,
    input  tpu_pkg::act_row_t wr_data_i,
    input  logic              rd_i,
    output tpu_pkg::act_row_t rd_data_o,
    output logic              full_o
);

    tpu_pkg::act_row_t mem [tpu_pkg::ARRAY_N];
    logic [1:0]        wr_ptr_q;
    logic [1:0]        rd_ptr_q;
    logic [2:0]        count_q;
    logic              push;
    logic              pop;

    assign push = wr_i && (count_q != 3'(tpu_pkg::ARRAY_N));
    assign pop  = rd_i && (count_q != 3'd0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 2'd1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 2'd1;
            end
            count_q <= count_q + 3'(push) - 3'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
        // registered pop data
        if (pop) begin
            rd_data_o <= mem[rd_ptr_q];
        end
    end

    assign full_o = (count_q == 3'(tpu_pkg::ARRAY_N));

endmodule

`default_nettype wire

// File: rtl/tile_control.sv
`timescale 1ns/1ps
`default_nettype none

module tile_control (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 cmd_valid_i,
    input  tpu_pkg::tpu_cmd_t    cmd_i,
    input  logic                 fifo_full_i,
    input  logic                 load_last_i,
    input  logic                 drain_last_i,
    input  logic                 tile_last_i,
    input  tpu_pkg::out_phase_e  phase_i,
    output tpu_pkg::tpu_cmd_t    cmd_o,
    output tpu_pkg::ctrl_state_e state_o,
    output logic                 load_weights_o,
    output logic                 compute_en_o,
    output logic                 cnt_clear_o,
    output logic                 busy_o,
    output logic                 done_o
);

    tpu_pkg::ctrl_state_e state_q;
    tpu_pkg::tpu_cmd_t    cmd_q;
    logic                 done_q;
    logic                 tile_end;

    // last drain cycle of a tile, column 3 alone still writing
    assign tile_end = drain_last_i && (phase_i == tpu_pkg::REVERSE_PARTIAL);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= tpu_pkg::IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                tpu_pkg::IDLE: begin
                    if (cmd_valid_i) begin
                        state_q <= tpu_pkg::FILL_FIFO;
                    end
                end
                tpu_pkg::FILL_FIFO: begin
                    if (fifo_full_i) begin
                        state_q <= tpu_pkg::LOAD_WEIGHTS;
                    end
                end
                tpu_pkg::LOAD_WEIGHTS: begin
                    if (load_last_i) begin
                        state_q <= tpu_pkg::COMPUTE;
                    end
                end
                tpu_pkg::COMPUTE: begin
                    if (tile_end) begin
                        if (tile_last_i) begin
                            state_q <= tpu_pkg::IDLE;
                            done_q  <= 1'b1;
                        end else begin
                            state_q <= tpu_pkg::FILL_FIFO;
                        end
                    end
                end
                default: begin
                    state_q <= tpu_pkg::IDLE;
                end
            endcase
        end
    end

    // command held for the whole run, strobes while busy are ignored
    always_ff @(posedge clk_i) begin
        if (state_q == tpu_pkg::IDLE && cmd_valid_i) begin
            cmd_q <= cmd_i;
        end
    end

    assign cmd_o          = cmd_q;
    assign state_o        = state_q;
    assign load_weights_o = (state_q == tpu_pkg::LOAD_WEIGHTS);
    assign compute_en_o   = (state_q == tpu_pkg::COMPUTE);
    assign cnt_clear_o    = (state_q == tpu_pkg::IDLE) || (state_q == tpu_pkg::FILL_FIFO);
    assign busy_o         = (state_q != tpu_pkg::IDLE);
    assign done_o         = done_q;

endmodule

`default_nettype wire

// File: rtl/tile_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tile_counter (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  tpu_pkg::tpu_cmd_t         cmd_i,
    input  tpu_pkg::ctrl_state_e      state_i,
    input  logic                      cnt_clear_i,
    input  logic                      compute_en_i,
    output logic                      load_last_o,
    output logic                      drain_last_o,
    output logic                      tile_last_o,
    output logic [tpu_pkg::UB_AW-1:0] ub_addr_o,
    output logic                      ub_rd_o,
    output logic                      act_valid_o,
    output tpu_pkg::acc_wr_t          acc_wr_o,
    output tpu_pkg::out_phase_e       phase_o
);

    logic [1:0]                load_cnt_q;
    logic [5:0]                comp_cnt_q;
    logic [1:0]                tile_cnt_q;
    logic [tpu_pkg::UB_AW-1:0] tile_off_q;
    logic                      act_valid_q;
    tpu_pkg::col_mask_t        mask;
    int                        wr_row;

    always_ff @(posedge clk_i) begin
        if (rst_i || cnt_clear_i) begin
            load_cnt_q <= '0;
            comp_cnt_q <= '0;
        end else begin
            if (state_i == tpu_pkg::LOAD_WEIGHTS) begin
                load_cnt_q <= load_cnt_q + 2'd1;
            end
            if (compute_en_i) begin
                comp_cnt_q <= comp_cnt_q + 6'd1;
            end
        end
    end

    // tile index and buffer offset of the current tile
    always_ff @(posedge clk_i) begin
        if (rst_i || state_i == tpu_pkg::IDLE) begin
            tile_cnt_q <= '0;
            tile_off_q <= '0;
        end else if (drain_last_o) begin
            tile_cnt_q <= tile_cnt_q + 2'd1;
            tile_off_q <= tile_off_q + tpu_pkg::UB_AW'(cmd_i.rows);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            act_valid_q <= 1'b0;
        end else begin
            act_valid_q <= ub_rd_o;
        end
    end

    assign load_last_o  = (state_i == tpu_pkg::LOAD_WEIGHTS) && (load_cnt_q == 2'd3);
    assign drain_last_o = compute_en_i &&
                          (comp_cnt_q == 6'(cmd_i.rows) + 6'(tpu_pkg::PIPE_LAT + 2));
    assign tile_last_o  = ({1'b0, tile_cnt_q} == cmd_i.tiles - 3'd1);
    assign ub_rd_o      = compute_en_i && (comp_cnt_q < 6'(cmd_i.rows));
    assign ub_addr_o    = cmd_i.ub_base + tile_off_q + tpu_pkg::UB_AW'(comp_cnt_q);
    assign act_valid_o  = act_valid_q;

    // column j holds row (count - PIPE_LAT - j)
    always_comb begin
        wr_row = int'(comp_cnt_q) - tpu_pkg::PIPE_LAT;
        for (int j = 0; j < tpu_pkg::ARRAY_N; j++) begin
            mask[j] = compute_en_i && (wr_row - j >= 0) && (wr_row - j < int'(cmd_i.rows));
        end
    end

    always_comb begin
        if (mask == '0) begin
            phase_o = tpu_pkg::NO_OUTPUT;
        end else if (mask == '1) begin
            phase_o = tpu_pkg::FULL_OUTPUT;
        end else if (mask[0]) begin
            phase_o = tpu_pkg::PARTIAL_OUTPUT;
        end else begin
            phase_o = tpu_pkg::REVERSE_PARTIAL;
        end
    end

    assign acc_wr_o.en       = |mask;
    assign acc_wr_o.add      = (tile_cnt_q != 2'd0);
    assign acc_wr_o.row      = tpu_pkg::ACC_AW'(wr_row);
    assign acc_wr_o.col_mask = mask;

endmodule

`default_nettype wire

// File: rtl/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_array (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              load_weight_i,
    input  tpu_pkg::act_row_t weight_row_i,
    input  logic              act_valid_i,
    input  tpu_pkg::act_row_t act_row_i,
    output tpu_pkg::acc_row_t psum_o
);

    localparam int N  = tpu_pkg::ARRAY_N;
    localparam int DW = tpu_pkg::DATA_W;
    localparam int AW = tpu_pkg::ACC_W;

    logic              load_q;
    tpu_pkg::act_row_t entry_q;
    logic [DW-1:0]     skew_q [N][N-1];
    logic [DW-1:0]     w_q    [N][N];
    logic [DW-1:0]     a_q    [N][N];
    logic [AW-1:0]     p_q    [N][N];

    // fifo data lags the pop by a cycle
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            load_q <= 1'b0;
        end else begin
            load_q <= load_weight_i;
        end
    end

    // invalid rows enter as zeros
    always_ff @(posedge clk_i) begin
        entry_q <= act_valid_i ? act_row_i : '0;
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        // element r waits r cycles before row r
        always_ff @(posedge clk_i) begin
            skew_q[r][0] <= entry_q[r];
            for (int k = 1; k < N-1; k++) begin
                skew_q[r][k] <= skew_q[r][k-1];
            end
        end

        for (genvar c = 0; c < N; c++) begin : g_col
            logic [DW-1:0]          a_in;
            logic [AW-1:0]          p_in;
            logic signed [2*DW-1:0] prod;

            assign a_in = (c != 0) ? a_q[r][(c == 0) ? 0 : c-1] :
                          (r == 0) ? entry_q[0] : skew_q[r][(r == 0) ? 0 : r-1];
            assign p_in = (r == 0) ? '0 : p_q[(r == 0) ? 0 : r-1][c];
            assign prod = $signed(a_in) * $signed(w_q[r][c]);

            always_ff @(posedge clk_i) begin
                // first row popped ends up in the bottom row
                if (load_q) begin
                    w_q[r][c] <= (r == 0) ? weight_row_i[c] : w_q[(r == 0) ? 0 : r-1][c];
                end
                a_q[r][c] <= a_in;
                p_q[r][c] <= p_in + {{(AW-2*DW){prod[2*DW-1]}}, prod};
            end
        end
    end

    for (genvar c = 0; c < N; c++) begin : g_out
        assign psum_o[c] = p_q[N-1][c];
    end

endmodule

`default_nettype wire

// File: rtl/accumulator_bank.sv
`timescale 1ns/1ps
`default_nettype none

module accumulator_bank (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  tpu_pkg::acc_wr_t           acc_wr_i,
    input  tpu_pkg::acc_row_t          psum_i,
    input  logic [tpu_pkg::ACC_AW-1:0] rd_addr_i,
    output tpu_pkg::acc_row_t          rd_data_o
);

    localparam int N     = tpu_pkg::ARRAY_N;
    localparam int DEPTH = tpu_pkg::MAX_ROWS;

    tpu_pkg::acc_row_t mem [DEPTH];

    // column j trails column 0 by j rows
    always_ff @(posedge clk_i) begin
        for (int j = 0; j < N; j++) begin
            if (!rst_i && acc_wr_i.en && acc_wr_i.col_mask[j]) begin
                if (acc_wr_i.add) begin
                    mem[acc_wr_i.row - tpu_pkg::ACC_AW'(j)][j] <=
                        mem[acc_wr_i.row - tpu_pkg::ACC_AW'(j)][j] + psum_i[j];
                end else begin
                    mem[acc_wr_i.row - tpu_pkg::ACC_AW'(j)][j] <= psum_i[j];
                end
            end
        end
    end

    assign rd_data_o = mem[rd_addr_i];

endmodule

`default_nettype wire

// File: rtl/tpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_core (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       cmd_valid_i,
    input  tpu_pkg::tpu_cmd_t          cmd_i,
    input  logic                       weight_wr_i,
    input  tpu_pkg::act_row_t          weight_row_i,
    output logic                       fifo_full_o,
    output logic [tpu_pkg::UB_AW-1:0]  ub_addr_o,
    output logic                       ub_rd_o,
    input  tpu_pkg::act_row_t          ub_data_i,
    output logic                       busy_o,
    output logic                       done_o,
    input  logic [tpu_pkg::ACC_AW-1:0] res_addr_i,
    output tpu_pkg::acc_row_t          res_data_o
);

    tpu_pkg::tpu_cmd_t    cmd;
    tpu_pkg::ctrl_state_e state;
    tpu_pkg::out_phase_e  phase;
    tpu_pkg::acc_wr_t     acc_wr;
    tpu_pkg::act_row_t    fifo_row;
    tpu_pkg::acc_row_t    psum;
    logic                 load_weights;
    logic                 compute_en;
    logic                 cnt_clear;
    logic                 load_last;
    logic                 drain_last;
    logic                 tile_last;
    logic                 act_valid;

    tile_control u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_i          (cmd_i),
        .fifo_full_i    (fifo_full_o),
        .load_last_i    (load_last),
        .drain_last_i   (drain_last),
        .tile_last_i    (tile_last),
        .phase_i        (phase),
        .cmd_o          (cmd),
        .state_o        (state),
        .load_weights_o (load_weights),
        .compute_en_o   (compute_en),
        .cnt_clear_o    (cnt_clear),
        .busy_o         (busy_o),
        .done_o         (done_o)
    );

    tile_counter u_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_i        (cmd),
        .state_i      (state),
        .cnt_clear_i  (cnt_clear),
        .compute_en_i (compute_en),
        .load_last_o  (load_last),
        .drain_last_o (drain_last),
        .tile_last_o  (tile_last),
        .ub_addr_o    (ub_addr_o),
        .ub_rd_o      (ub_rd_o),
        .act_valid_o  (act_valid),
        .acc_wr_o     (acc_wr),
        .phase_o      (phase)
    );

    weight_fifo u_fifo (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wr_i      (weight_wr_i),
        .wr_data_i (weight_row_i),
        .rd_i      (load_weights),
        .rd_data_o (fifo_row),
        .full_o    (fifo_full_o)
    );

    systolic_array u_array (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .load_weight_i (load_weights),
        .weight_row_i  (fifo_row),
        .act_valid_i   (act_valid),
        .act_row_i     (ub_data_i),
        .psum_o        (psum)
    );

    accumulator_bank u_acc (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .acc_wr_i  (acc_wr),
        .psum_i    (psum),
        .rd_addr_i (res_addr_i),
        .rd_data_o (res_data_o)
    );

endmodule

`default_nettype wire

// File: tb/tpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tpu_checker (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       cmd_valid_i,
    input  tpu_pkg::tpu_cmd_t          cmd_i,
    input  logic                       weight_wr_i,
    input  tpu_pkg::act_row_t          weight_row_i,
    input  logic                       fifo_full_i,
    input  logic [tpu_pkg::UB_AW-1:0]  ub_addr_i,
    input  logic                       ub_rd_i,
    input  tpu_pkg::act_row_t          ub_data_i,
    input  logic                       busy_i,
    input  logic                       done_i,
    input  logic [tpu_pkg::ACC_AW-1:0] res_addr_i,
    input  tpu_pkg::acc_row_t          res_data_i,
    input  logic                       sweep_i,
    output int                         test_cnt_o,
    output int                         check_cnt_o,
    output int                         err_cnt_o
);

    tpu_pkg::tpu_cmd_t cmd_q;
    tpu_pkg::act_row_t a_rows [$];
    tpu_pkg::act_row_t w_rows [$];
    tpu_pkg::acc_row_t exp_acc [tpu_pkg::MAX_ROWS];
    logic              written [tpu_pkg::MAX_ROWS];
    logic              started;
    logic              accepted_q;
    logic              rd_pending;
    logic              done_q;
    logic              sweep_q;
    logic              full_due;
    int                pending_cmds;
    int                test_errs;
    int                test_cnt = 0;
    int                check_cnt = 0;
    int                err_cnt = 0;

    assign test_cnt_o  = test_cnt;
    assign check_cnt_o = check_cnt;
    assign err_cnt_o   = err_cnt;

    initial begin
        for (int r = 0; r < tpu_pkg::MAX_ROWS; r++) begin
            written[r] = 1'b0;
        end
    end

    task automatic report(input string msg);
        $display("at %0d ns: %s", $time, msg);
        err_cnt++;
        test_errs++;
    endtask

    // C = sum over tiles of A_k x W_k, pushed row p feeds activation element 3-p
    task automatic build_expected();
        int                rows;
        int                tiles;
        logic signed [31:0] sum;
        tpu_pkg::act_row_t a;
        tpu_pkg::act_row_t w;
        rows  = cmd_q.rows;
        tiles = cmd_q.tiles;
        if (a_rows.size() != rows * tiles || w_rows.size() < tiles * 4) begin
            report($sformatf("command read %0d buffer rows with %0d weight rows queued",
                             a_rows.size(), w_rows.size()));
        end else begin
            for (int r = 0; r < rows; r++) begin
                for (int j = 0; j < tpu_pkg::ARRAY_N; j++) begin
                    sum = 0;
                    for (int k = 0; k < tiles; k++) begin
                        a = a_rows[k * rows + r];
                        for (int p = 0; p < tpu_pkg::ARRAY_N; p++) begin
                            w = w_rows[k * 4 + p];
                            sum += $signed(a[3 - p]) * $signed(w[j]);
                        end
                    end
                    exp_acc[r][j] = sum;
                end
                written[r] = 1'b1;
            end
            repeat (tiles * 4) void'(w_rows.pop_front());
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_i) begin
            started      = 1'b0;
            accepted_q   = 1'b0;
            rd_pending   = 1'b0;
            done_q       = 1'b0;
            sweep_q      = 1'b0;
            full_due     = 1'b0;
            pending_cmds = 0;
            test_errs    = 0;
        end else begin
            if (accepted_q && !busy_i) begin
                report("busy_o did not rise the cycle after an accepted command");
            end
            if (!started && (ub_rd_i || busy_i || done_i)) begin
                report("DUT became active before any command was sent");
            end
            if (rd_pending) begin
                a_rows.push_back(ub_data_i);
            end
            rd_pending = ub_rd_i;
            if (ub_rd_i && ub_addr_i !== tpu_pkg::UB_AW'(cmd_q.ub_base + a_rows.size())) begin
                $display("Error at %0d ns: buffer address 0x%02h, expected 0x%02h", $time,
                         ub_addr_i, tpu_pkg::UB_AW'(cmd_q.ub_base + a_rows.size()));
                err_cnt++;
                test_errs++;
            end
            // no pop can happen before the first tile is full
            if (full_due && !fifo_full_i) begin
                $display("Error at %0d ns: fifo_full_o low after the fourth weight row",
                         $time);
                err_cnt++;
                test_errs++;
            end
            full_due = 1'b0;
            if (weight_wr_i && !fifo_full_i) begin
                w_rows.push_back(weight_row_i);
                full_due = (w_rows.size() == tpu_pkg::ARRAY_N);
            end
            accepted_q = cmd_valid_i && !busy_i;
            if (accepted_q) begin
                started = 1'b1;
                cmd_q   = cmd_i;
                a_rows.delete();
                pending_cmds++;
            end
            if (done_i) begin
                if (done_q) begin
                    report("done_o stayed high for more than one cycle");
                end
                if (busy_i) begin
                    report("busy_o was still high during the done_o pulse");
                end
                if (pending_cmds == 0) begin
                    report("done_o pulsed without an accepted command");
                end else begin
                    pending_cmds--;
                    build_expected();
                end
            end
            done_q = done_i;
            if (sweep_i && written[res_addr_i]) begin
                check_cnt++;
                for (int j = 0; j < tpu_pkg::ARRAY_N; j++) begin
                    if (res_data_i[j] !== exp_acc[res_addr_i][j]) begin
                        $display("Error at %0d ns: row %0d col %0d is %0d, expected %0d",
                                 $time, res_addr_i, j, $signed(res_data_i[j]),
                                 $signed(exp_acc[res_addr_i][j]));
                        err_cnt++;
                        test_errs++;
                    end
                end
            end
            // end of a result sweep closes the test
            if (sweep_q && !sweep_i) begin
                $display("test %0d: rows %0d tiles %0d base 0x%02h, %0d errors",
                         test_cnt, cmd_q.rows, cmd_q.tiles, cmd_q.ub_base, test_errs);
                test_cnt++;
                test_errs = 0;
            end
            sweep_q = sweep_i;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_tpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tpu_core;

    localparam int NUM_TESTS = 6;

    typedef struct packed {
        logic [4:0] rows;
        logic [2:0] tiles;
        logic [7:0] ub_base;
        logic [3:0] gap;
        logic       stray;
    } test_entry_t;

    // rows, tiles, ub_base, push gap, stray strobe while busy
    test_entry_t test_tbl [NUM_TESTS] = '{
        {5'd4,  3'd1, 8'h00, 4'd0, 1'b0},
        {5'd16, 3'd3, 8'h10, 4'd0, 1'b0},
        {5'd1,  3'd2, 8'h48, 4'd1, 1'b0},
        {5'd7,  3'd1, 8'h50, 4'd0, 1'b0},
        {5'd5,  3'd2, 8'h60, 4'd5, 1'b0},
        {5'd8,  3'd2, 8'h80, 4'd2, 1'b1}
    };

    logic                       clk_i = 1'b0;
    logic                       rst_i;
    logic                       cmd_valid_i;
    tpu_pkg::tpu_cmd_t          cmd_i;
    logic                       weight_wr_i;
    tpu_pkg::act_row_t          weight_row_i;
    logic                       fifo_full_o;
    logic [tpu_pkg::UB_AW-1:0]  ub_addr_o;
    logic                       ub_rd_o;
    tpu_pkg::act_row_t          ub_data_i;
    logic                       busy_o;
    logic                       done_o;
    logic [tpu_pkg::ACC_AW-1:0] res_addr_i;
    tpu_pkg::acc_row_t          res_data_o;
    logic                       sweep;
    logic [31:0]                lcg_state;
    int                         test_cnt;
    int                         check_cnt;
    int                         err_cnt;
    tpu_pkg::act_row_t          ub_mem [256];
    tpu_pkg::act_row_t          w_rows [tpu_pkg::MAX_TILES * tpu_pkg::ARRAY_N];

    always #4 clk_i = ~clk_i;

    // unified buffer model, one cycle read latency
    always @(posedge clk_i) begin
        if (ub_rd_o) begin
            ub_data_i <= ub_mem[ub_addr_o];
        end
    end

    tpu_core dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .weight_wr_i  (weight_wr_i),
        .weight_row_i (weight_row_i),
        .fifo_full_o  (fifo_full_o),
        .ub_addr_o    (ub_addr_o),
        .ub_rd_o      (ub_rd_o),
        .ub_data_i    (ub_data_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .res_addr_i   (res_addr_i),
        .res_data_o   (res_data_o)
    );

    tpu_checker chk0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_i        (cmd_i),
        .weight_wr_i  (weight_wr_i),
        .weight_row_i (weight_row_i),
        .fifo_full_i  (fifo_full_o),
        .ub_addr_i    (ub_addr_o),
        .ub_rd_i      (ub_rd_o),
        .ub_data_i    (ub_data_i),
        .busy_i       (busy_o),
        .done_i       (done_o),
        .res_addr_i   (res_addr_i),
        .res_data_i   (res_data_o),
        .sweep_i      (sweep),
        .test_cnt_o   (test_cnt),
        .check_cnt_o  (check_cnt),
        .err_cnt_o    (err_cnt)
    );

    function automatic tpu_pkg::act_row_t rand_row();
        tpu_pkg::act_row_t row;
        for (int i = 0; i < tpu_pkg::ARRAY_N; i++) begin
            lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
            row[i] = lcg_state[23:16];
        end
        return row;
    endfunction

    function automatic int watchdog_cycles();
        int total;
        total = 200;
        for (int i = 0; i < NUM_TESTS; i++) begin
            total += test_tbl[i].tiles * (test_tbl[i].gap * 4 + test_tbl[i].rows + 20);
        end
        return total;
    endfunction

    task automatic push_weights(input int n, input int gap);
        for (int w = 0; w < n; w++) begin
            repeat (gap) @(posedge clk_i);
            do @(negedge clk_i); while (fifo_full_o);
            @(posedge clk_i);
            weight_wr_i  <= 1'b1;
            // last row of a tile first, so row i ends up in array row i
            weight_row_i <= w_rows[(w / 4) * 4 + 3 - (w % 4)];
            @(posedge clk_i);
            weight_wr_i  <= 1'b0;
        end
    endtask

    task automatic run_test(input test_entry_t e);
        tpu_pkg::tpu_cmd_t cmd;
        tpu_pkg::tpu_cmd_t stray;
        for (int a = 0; a < e.rows * e.tiles; a++) begin
            ub_mem[tpu_pkg::UB_AW'(e.ub_base + a)] = rand_row();
        end
        for (int w = 0; w < e.tiles * 4; w++) begin
            w_rows[w] = rand_row();
        end
        cmd.rows    = e.rows;
        cmd.tiles   = e.tiles;
        cmd.ub_base = e.ub_base;
        stray.rows    = 5'd3;
        stray.tiles   = 3'd1;
        stray.ub_base = 8'hf0;
        @(posedge clk_i);
        cmd_valid_i <= 1'b1;
        cmd_i       <= cmd;
        @(posedge clk_i);
        cmd_valid_i <= 1'b0;
        if (e.stray) begin
            @(posedge clk_i);
            cmd_valid_i <= 1'b1;
            cmd_i       <= stray;
            @(posedge clk_i);
            cmd_valid_i <= 1'b0;
        end
        push_weights(e.tiles * 4, e.gap);
        do @(negedge clk_i); while (!done_o);
        @(posedge clk_i);
        sweep <= 1'b1;
        for (int r = 0; r < tpu_pkg::MAX_ROWS; r++) begin
            res_addr_i <= tpu_pkg::ACC_AW'(r);
            @(posedge clk_i);
        end
        sweep <= 1'b0;
    endtask

    initial begin
        rst_i        = 1'b1;
        cmd_valid_i  = 1'b0;
        cmd_i        = '0;
        weight_wr_i  = 1'b0;
        weight_row_i = '0;
        ub_data_i    = '0;
        res_addr_i   = '0;
        sweep        = 1'b0;
        lcg_state    = 32'd31824;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) @(posedge clk_i);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(test_tbl[t]);
        end
        repeat (2) @(posedge clk_i);
        $display("tests %0d of %0d, checks %0d, errors %0d",
                 test_cnt, NUM_TESTS, check_cnt, err_cnt);
        if (err_cnt == 0 && test_cnt == NUM_TESTS) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the DUT stopped making progress", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/tpu_pkg.sv
rtl/weight_fifo.sv
rtl/tile_control.sv
rtl/tile_counter.sv
rtl/systolic_array.sv
rtl/accumulator_bank.sv
rtl/tpu_core.sv
tb/tpu_checker.sv
tb/tb_tpu_core.sv

// File: Bender.yml
package:
  name: tpu_core

sources:
  - rtl/tpu_pkg.sv
  - rtl/weight_fifo.sv
  - rtl/tile_control.sv
  - rtl/tile_counter.sv
  - rtl/systolic_array.sv
  - rtl/accumulator_bank.sv
  - rtl/tpu_core.sv
  - target: test
    files:
      - tb/tpu_checker.sv
      - tb/tb_tpu_core.sv
